// File: source/exec_pkg.sv
// Shared types, flag positions, ALU encodings and reset values; import into execution stage blocks.
`default_nettype none

package exec_pkg;

  typedef logic [15:0] word_t;
  typedef logic [19:0] phys_addr_t;
  typedef logic [3:0]  reg_sel_t;
  typedef logic [8:0]  flags_t;

  // flag positions inside flags_t run from of down to cf.
  localparam int flag_of = 8;
  localparam int flag_df = 7;
  localparam int flag_if = 6;
  localparam int flag_tf = 5;
  localparam int flag_sf = 4;
  localparam int flag_zf = 3;
  localparam int flag_af = 2;
  localparam int flag_pf = 1;
  localparam int flag_cf = 0;

  typedef enum logic [2:0] {
    alu_arith = 3'd0,
    alu_shift = 3'd1,
    alu_addr  = 3'd2
  } alu_type_e;

  // arithmetic and logic functions follow the x86 group-1 order.
  typedef enum logic [2:0] {
    func_add    = 3'd0,
    func_or     = 3'd1,
    func_adc    = 3'd2,
    func_sbb    = 3'd3,
    func_and    = 3'd4,
    func_sub    = 3'd5,
    func_xor    = 3'd6,
    func_pass_b = 3'd7
  } alu_func_e;

  // shift functions reuse the func field with the x86 group-2 codes.
  localparam alu_func_e func_rol = alu_func_e'(3'd0);
  localparam alu_func_e func_ror = alu_func_e'(3'd1);
  localparam alu_func_e func_shl = alu_func_e'(3'd4);
  localparam alu_func_e func_shr = alu_func_e'(3'd5);
  localparam alu_func_e func_sar = alu_func_e'(3'd7);

  typedef struct packed {
    logic [2:0] rsvd;      // reserved microcode bits
    logic       r_byte;    // byte width for multiply and divide sources
    logic       b_imm;
    logic       m_io;
    logic       mem_alu;
    logic       byte_op;
    alu_func_e  func;
    alu_type_e  op_type;
    logic       wr_cnd;
    logic       wr;
    logic       mem_we;
    logic       wr_flags;
    reg_sel_t   addr_d;
    reg_sel_t   addr_c;
    reg_sel_t   addr_b;
    reg_sel_t   addr_a;
    logic [1:0] addr_s;
  } micro_op_t;

  localparam word_t  cs_reset    = 16'hf000;
  localparam word_t  ip_reset    = 16'hfff0;
  localparam word_t  reg_reset   = 16'h0000;
  localparam flags_t flags_reset = 9'h000;

endpackage

`default_nettype wire

// File: source/exec_regfile.sv
// Register file with general, segment, ip and flags registers; three read ports plus a segment port.
`default_nettype none

module exec_regfile import exec_pkg::*; #(
  parameter int num_gp_regs = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  reg_sel_t   addr_a,
  input  reg_sel_t   addr_b,
  input  reg_sel_t   addr_c,
  input  reg_sel_t   addr_d,
  input  logic [1:0] addr_s,
  input  word_t      wr_data,
  input  logic       wr_en,
  input  logic       wr_flags_en,
  input  logic       byte_wr,
  input  flags_t     flags_in,
  output word_t      a,
  output word_t      b,
  output word_t      c,
  output word_t      s,
  output word_t      cs,
  output word_t      ip,
  output flags_t     flags,
  output logic       cx_zero
);

  // segment registers sit right above the general registers, ip after them.
  localparam int seg_base = num_gp_regs;
  localparam int ip_code  = num_gp_regs + 4;
  localparam int seg_cs   = 1;
  localparam int gp_cx    = 1;

  word_t  gp_q [num_gp_regs];
  word_t  seg_q [4];
  word_t  ip_q;
  flags_t flags_q;
  int     wr_idx;

  // byte accesses to codes 0..7 select al..bl and ah..bh, zero extended.
  function automatic word_t read_reg(input reg_sel_t sel, input logic byte_mode);
    int    idx;
    word_t val;
    idx = int'(sel);
    val = '0;
    if (byte_mode && idx < 8) begin
      val = idx[2] ? {8'h00, gp_q[idx[1:0]][15:8]} : {8'h00, gp_q[idx[1:0]][7:0]};
    end else if (idx < num_gp_regs) begin
      val = gp_q[idx];
    end else if (idx >= seg_base && idx < seg_base + 4) begin
      val = seg_q[idx - seg_base];
    end else if (idx == ip_code) begin
      val = ip_q;
    end
    return val;
  endfunction

  assign a       = read_reg(addr_a, byte_wr);
  assign b       = read_reg(addr_b, byte_wr);
  assign c       = read_reg(addr_c, byte_wr);
  assign s       = seg_q[addr_s];
  assign cs      = seg_q[seg_cs];
  assign ip      = ip_q;
  assign flags   = flags_q;
  assign cx_zero = (gp_q[gp_cx] == 16'h0000);
  assign wr_idx  = int'(addr_d);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_gp_regs; i++) begin
        gp_q[i] <= reg_reset;
      end
      for (int i = 0; i < 4; i++) begin
        seg_q[i] <= (i == seg_cs) ? cs_reset : reg_reset;
      end
      ip_q    <= ip_reset;
      flags_q <= flags_reset;
    end else begin
      if (wr_en) begin
        if (byte_wr && wr_idx < 8) begin
          if (wr_idx[2]) begin
            gp_q[wr_idx[1:0]][15:8] <= wr_data[7:0];
          end else begin
            gp_q[wr_idx[1:0]][7:0] <= wr_data[7:0];
          end
        end else if (wr_idx < num_gp_regs) begin
          gp_q[wr_idx] <= wr_data;
        end else if (wr_idx >= seg_base && wr_idx < seg_base + 4) begin
          seg_q[wr_idx - seg_base] <= wr_data;
        end else if (wr_idx == ip_code) begin
          ip_q <= wr_data;
        end
      end
      if (wr_flags_en) begin
        flags_q <= flags_in;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/exec_alu.sv
// Combinational ALU of the execution stage for add and logic, one-bit shifts and segment sums.
`default_nettype none

module exec_alu import exec_pkg::*; (
  input  word_t      a,
  input  word_t      b,
  input  word_t      s,
  input  word_t      off,
  input  alu_type_e  op_type,
  input  alu_func_e  func,
  input  logic       word_op,
  input  flags_t     flags_in,
  output phys_addr_t result,
  output flags_t     flags_out
);

  word_t      mask;
  word_t      top_bit;
  word_t      aw;
  word_t      bx;
  logic       is_sub;
  logic       cin;
  logic [16:0] sum17;
  logic [8:0]  sum9;
  word_t      res;
  logic       msb_in;
  phys_addr_t addr_sum;

  assign mask    = word_op ? 16'hffff : 16'h00ff;
  assign top_bit = word_op ? 16'h8000 : 16'h0080;
  assign aw      = a & mask;
  assign msb_in  = |(a & top_bit);

  // subtraction runs as a + ~b + ~borrow.
  assign is_sub = (func == func_sub) || (func == func_sbb);
  assign cin    = ((func == func_adc || func == func_sbb) ? flags_in[flag_cf] : 1'b0) ^ is_sub;
  assign bx     = is_sub ? ~b : b;
  assign sum17  = {1'b0, a} + {1'b0, bx} + 17'(cin);
  assign sum9   = {1'b0, a[7:0]} + {1'b0, bx[7:0]} + 9'(cin);

  assign addr_sum = {s, 4'h0} + {4'h0, a} + {4'h0, off};

  always_comb begin
    res       = '0;
    flags_out = flags_in;
    case (op_type)
      alu_arith: begin
        case (func)
          func_or:     res = (a | b) & mask;
          func_and:    res = (a & b) & mask;
          func_xor:    res = (a ^ b) & mask;
          func_pass_b: res = b;
          default:     res = word_op ? sum17[15:0] : {8'h00, sum9[7:0]};
        endcase
        if (func != func_pass_b) begin
          if (func == func_or || func == func_and || func == func_xor) begin
            flags_out[flag_cf] = 1'b0;
            flags_out[flag_of] = 1'b0;
            flags_out[flag_af] = 1'b0;
          end else begin
            flags_out[flag_cf] = (word_op ? sum17[16] : sum9[8]) ^ is_sub;
            flags_out[flag_af] = a[4] ^ b[4] ^ res[4];
            flags_out[flag_of] = word_op ? (a[15] == bx[15]) && (res[15] != a[15])
                                         : (a[7] == bx[7]) && (res[7] != a[7]);
          end
          flags_out[flag_sf] = |(res & top_bit);
          flags_out[flag_zf] = (res == 16'h0000);
          flags_out[flag_pf] = ~^res[7:0];
        end
      end
      alu_shift: begin
        res = a;
        case (func)
          func_shl, func_rol: begin
            res = ((aw << 1) & mask) | ((func == func_rol) ? 16'(msb_in) : 16'h0000);
            flags_out[flag_cf] = msb_in;
            flags_out[flag_of] = |(res & top_bit) ^ msb_in;
          end
          func_shr: begin
            res = aw >> 1;
            flags_out[flag_cf] = a[0];
            flags_out[flag_of] = msb_in;
          end
          func_sar, func_ror: begin
            res = (aw >> 1) | ((func == func_sar ? msb_in : a[0]) ? top_bit : 16'h0000);
            flags_out[flag_cf] = a[0];
            flags_out[flag_of] = (func == func_sar) ? 1'b0
                               : |(res & top_bit) ^ |(res & (top_bit >> 1));
          end
          default: ;
        endcase
        // plain shifts also update the result flags but rotates do not.
        if (func == func_shl || func == func_shr || func == func_sar) begin
          flags_out[flag_sf] = |(res & top_bit);
          flags_out[flag_zf] = (res == 16'h0000);
          flags_out[flag_pf] = ~^res[7:0];
          flags_out[flag_af] = 1'b0;
        end
      end
      default: ;
    endcase
  end

  assign result = (op_type == alu_addr) ? addr_sum : {4'h0, res};

endmodule

`default_nettype wire

// File: source/exec_jmp_cond.sv
// Branch condition evaluator for conditional register writes, driven by flags and the cx count.
`default_nettype none

module exec_jmp_cond import exec_pkg::*; (
  input  flags_t   flags,
  input  logic     cx_zero,
  input  reg_sel_t cond,
  input  logic     invert,
  output logic     jmp
);

  logic base;
  logic s_xor_o;

  assign s_xor_o = flags[flag_sf] ^ flags[flag_of];

  // the eight x86 condition pairs; upper codes are the loop test on cx.
  always_comb begin
    if (cond[3]) begin
      base = ~cx_zero;
    end else begin
      case (cond[2:0])
        3'd0:    base = flags[flag_of];
        3'd1:    base = flags[flag_cf];
        3'd2:    base = flags[flag_zf];
        3'd3:    base = flags[flag_cf] | flags[flag_zf];
        3'd4:    base = flags[flag_sf];
        3'd5:    base = flags[flag_pf];
        3'd6:    base = s_xor_o;
        default: base = flags[flag_zf] | s_xor_o;
      endcase
    end
  end

  assign jmp = base ^ invert;

endmodule

`default_nettype wire

// File: source/exec_stage.sv
// Top of the execution stage; decodes one micro-op per cycle into register writes and bus signals.
`default_nettype none

module exec_stage import exec_pkg::*; #(
  parameter int num_gp_regs = 8
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       block,
  input  micro_op_t  ir,
  input  word_t      off,
  input  word_t      imm,
  input  word_t      memout,
  output word_t      cs,
  output word_t      ip,
  output word_t      wr_data,
  output phys_addr_t addr,
  output logic       we,
  output logic       m_io,
  output logic       byteop,
  output logic       of,
  output logic       zf,
  output logic       ifl,
  output logic       cx_zero
);

  word_t      reg_a;
  word_t      reg_b;
  word_t      reg_c;
  word_t      seg;
  word_t      bus_b;
  word_t      wb_data;
  phys_addr_t alu_out;
  flags_t     flags;
  flags_t     new_flags;
  logic       jmp;
  logic       wr_reg;
  logic       wr_fl;

  // ##################################################
  // operand and write-back selection

  assign bus_b   = ir.b_imm ? imm : reg_b;
  assign wb_data = ir.mem_alu ? alu_out[15:0] : memout;

  // a held stage keeps its state but still shows the bus request.
  assign wr_reg = (ir.wr | (ir.wr_cnd & jmp)) & ~block;
  assign wr_fl  = ir.wr_flags & ~block;

  // ##################################################
  // datapath blocks

  exec_regfile #(
    .num_gp_regs (num_gp_regs)
  ) i_regfile (
    .clk         (clk),
    .rst         (rst),
    .addr_a      (ir.addr_a),
    .addr_b      (ir.addr_b),
    .addr_c      (ir.addr_c),
    .addr_d      (ir.addr_d),
    .addr_s      (ir.addr_s),
    .wr_data     (wb_data),
    .wr_en       (wr_reg),
    .wr_flags_en (wr_fl),
    .byte_wr     (ir.byte_op),
    .flags_in    (new_flags),
    .a           (reg_a),
    .b           (reg_b),
    .c           (reg_c),
    .s           (seg),
    .cs          (cs),
    .ip          (ip),
    .flags       (flags),
    .cx_zero     (cx_zero)
  );

  exec_alu i_alu (
    .a         (reg_a),
    .b         (bus_b),
    .s         (seg),
    .off       (off),
    .op_type   (ir.op_type),
    .func      (ir.func),
    .word_op   (~ir.byte_op),
    .flags_in  (flags),
    .result    (alu_out),
    .flags_out (new_flags)
  );

  // the condition code rides in addr_b and the polarity in addr_c bit 0.
  exec_jmp_cond i_jmp_cond (
    .flags   (flags),
    .cx_zero (cx_zero),
    .cond    (ir.addr_b),
    .invert  (ir.addr_c[0]),
    .jmp     (jmp)
  );

  // ##################################################
  // bus side

  assign addr    = alu_out;
  assign wr_data = reg_c;
  assign we      = ir.mem_we;
  assign m_io    = ir.m_io;
  assign byteop  = ir.byte_op;
  assign of      = flags[flag_of];
  assign zf      = flags[flag_zf];
  assign ifl     = flags[flag_if];

endmodule

`default_nettype wire

// File: testbench/tb_exec_model.svh
// Reference model of register image, ALU and branch conditions; included by the stage testbench.
`ifndef TB_EXEC_MODEL_SVH
`define TB_EXEC_MODEL_SVH

// register image indexed by selector code; codes 13 to 15 are never written and read as zero.
typedef logic [15:0][15:0] reg_image_t;

function automatic word_t read_model(input reg_image_t regs, input reg_sel_t sel,
                                     input logic byte_mode);
  word_t val;
  if (byte_mode && sel < 4'd8) begin
    val = sel[2] ? {8'h00, regs[sel[1:0]][15:8]} : {8'h00, regs[sel[1:0]][7:0]};
  end else begin
    val = regs[sel];
  end
  return val;
endfunction

function automatic reg_image_t write_model(input reg_image_t regs, input reg_sel_t sel,
                                           input logic byte_mode, input word_t d);
  reg_image_t upd;
  upd = regs;
  if (byte_mode && sel < 4'd8) begin
    if (sel[2]) begin
      upd[sel[1:0]][15:8] = d[7:0];
    end else begin
      upd[sel[1:0]][7:0] = d[7:0];
    end
  end else if (sel < 4'd13) begin
    upd[sel] = d;
  end
  return upd;
endfunction

function automatic flags_t with_result_flags(input flags_t f, input word_t res,
                                             input word_t top);
  flags_t out_f;
  out_f = f;
  out_f[flag_sf] = |(res & top);
  out_f[flag_zf] = (res == 16'h0000);
  out_f[flag_pf] = ~^res[7:0];
  return out_f;
endfunction

// carry is the x86 borrow on subtraction and overflow is the signed range check.
function automatic void alu_model(input alu_type_e t, input alu_func_e f, input logic wide,
                                  input word_t a, input word_t b, input word_t s,
                                  input word_t off_v, input flags_t fi,
                                  output phys_addr_t r, output flags_t fo);
  word_t       m;
  word_t       top;
  word_t       aw;
  word_t       res;
  logic [16:0] full;
  logic        c;
  logic        msb;
  logic        low;
  int          lin;
  m   = wide ? 16'hffff : 16'h00ff;
  top = wide ? 16'h8000 : 16'h0080;
  aw  = a & m;
  msb = wide ? a[15] : a[7];
  c   = (f == func_adc || f == func_sbb) ? fi[flag_cf] : 1'b0;
  res = a;
  fo  = fi;
  r   = '0;
  if (t == alu_arith) begin
    case (f)
      func_add, func_adc: begin
        full = {1'b0, aw} + {1'b0, b & m} + 17'(c);
        res  = full[15:0] & m;
        fo[flag_cf] = wide ? full[16] : full[8];
        fo[flag_of] = |((a ^ res) & (b ^ res) & top);
      end
      func_sub, func_sbb: begin
        full = {1'b0, aw} - {1'b0, b & m} - 17'(c);
        res  = full[15:0] & m;
        fo[flag_cf] = wide ? full[16] : full[8];
        fo[flag_of] = |((a ^ b) & (a ^ res) & top);
      end
      func_pass_b: res = b;
      default: begin
        res = (f == func_or) ? (a | b) & m : (f == func_and) ? (a & b) & m : (a ^ b) & m;
        fo[flag_cf] = 1'b0;
        fo[flag_of] = 1'b0;
      end
    endcase
    if (f != func_pass_b) begin
      fo[flag_af] = (f == func_or || f == func_and || f == func_xor) ? 1'b0
                                                                    : a[4] ^ b[4] ^ res[4];
      fo = with_result_flags(fo, res, top);
    end
    r = {4'h0, res};
  end else if (t == alu_shift) begin
    case (f)
      func_shl, func_rol: begin
        low = (f == func_rol) ? msb : 1'b0;
        res = wide ? {a[14:0], low} : {8'h00, a[6:0], low};
        fo[flag_cf] = msb;
        fo[flag_of] = (wide ? res[15] : res[7]) ^ msb;
      end
      func_shr: begin
        res = wide ? {1'b0, a[15:1]} : {8'h00, 1'b0, a[7:1]};
        fo[flag_cf] = a[0];
        fo[flag_of] = msb;
      end
      func_sar: begin
        res = wide ? {a[15], a[15:1]} : {8'h00, a[7], a[7:1]};
        fo[flag_cf] = a[0];
        fo[flag_of] = 1'b0;
      end
      func_ror: begin
        res = wide ? {a[0], a[15:1]} : {8'h00, a[0], a[7:1]};
        fo[flag_cf] = a[0];
        fo[flag_of] = wide ? res[15] ^ res[14] : res[7] ^ res[6];
      end
      default: ;
    endcase
    if (f == func_shl || f == func_shr || f == func_sar) begin
      fo[flag_af] = 1'b0;
      fo = with_result_flags(fo, res, top);
    end
    r = {4'h0, res};
  end else if (t == alu_addr) begin
    // the segment counts in 16-byte paragraphs and the sum wraps at 1 MiB.
    lin = int'(s) * 16 + int'(a) + int'(off_v);
    r   = phys_addr_t'(lin % (1 << 20));
  end
endfunction

function automatic logic cond_model(input flags_t f, input word_t cx, input reg_sel_t code,
                                    input logic inv);
  logic so;
  logic taken;
  so = f[flag_sf] ^ f[flag_of];
  case (code)
    4'd0:    taken = f[flag_of];
    4'd1:    taken = f[flag_cf];
    4'd2:    taken = f[flag_zf];
    4'd3:    taken = f[flag_cf] | f[flag_zf];
    4'd4:    taken = f[flag_sf];
    4'd5:    taken = f[flag_pf];
    4'd6:    taken = so;
    4'd7:    taken = f[flag_zf] | so;
    default: taken = (cx != 16'h0000);
  endcase
  return taken ^ inv;
endfunction

`endif

// File: testbench/tb_exec_stage.sv
// Self-checking testbench for the execution stage; built and run by the Verilator script.
`default_nettype none

module tb_exec_stage import exec_pkg::*; ();

  `include "tb_exec_model.svh"

  localparam int gp_count     = 8;
  localparam int reset_cycles = 10;
  localparam int arith_runs   = 24;
  localparam int byte_runs    = 8;
  localparam int shift_runs   = 20;
  localparam int cond_runs    = 32;
  localparam int block_runs   = 4;
  localparam int addr_runs    = 20;
  // one clock per step, and the limit allows twice the total.
  localparam int max_cycles   = 2 * (reset_cycles + 1 + 4 * arith_runs + 3 * byte_runs
                                + 3 * shift_runs + 4 * cond_runs + 4 * block_runs
                                + 3 * addr_runs);

  logic       clk;
  logic       rst;
  logic       block;
  micro_op_t  ir;
  word_t      off;
  word_t      imm;
  word_t      memout;
  word_t      cs;
  word_t      ip;
  word_t      wr_data;
  phys_addr_t addr;
  logic       we;
  logic       m_io;
  logic       byteop;
  logic       of;
  logic       zf;
  logic       ifl;
  logic       cx_zero;
  reg_image_t shadow;
  flags_t     flags_q;
  alu_func_e  shift_funcs [5];
  int         errors;
  int         checks;
  int         cycles;

  exec_stage #(
    .num_gp_regs (gp_count)
  ) i_dut (
    .clk     (clk),
    .rst     (rst),
    .block   (block),
    .ir      (ir),
    .off     (off),
    .imm     (imm),
    .memout  (memout),
    .cs      (cs),
    .ip      (ip),
    .wr_data (wr_data),
    .addr    (addr),
    .we      (we),
    .m_io    (m_io),
    .byteop  (byteop),
    .of      (of),
    .zf      (zf),
    .ifl     (ifl),
    .cx_zero (cx_zero)
  );

  always #20 clk = ~clk;

  // ##################################################
  // checking and stepping

  task automatic check_equal(input string name, input logic [19:0] got,
                             input logic [19:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      errors++;
    end
  endtask

  // drives one microinstruction, checks all outputs mid-cycle, then commits the expected write.
  task automatic step(input micro_op_t op, input logic hold, input word_t imm_v,
                      input word_t off_v, input word_t mem_v);
    word_t      ra;
    word_t      rb;
    word_t      rc;
    phys_addr_t exp_addr;
    flags_t     exp_flags;
    logic       taken;
    @(posedge clk);
    ir     <= op;
    block  <= hold;
    imm    <= imm_v;
    off    <= off_v;
    memout <= mem_v;
    ra = read_model(shadow, op.addr_a, op.byte_op);
    rb = op.b_imm ? imm_v : read_model(shadow, op.addr_b, op.byte_op);
    rc = read_model(shadow, op.addr_c, op.byte_op);
    // segment registers sit at selector codes 8 to 11.
    alu_model(op.op_type, op.func, ~op.byte_op, ra, rb, shadow[{2'b10, op.addr_s}], off_v,
              flags_q, exp_addr, exp_flags);
    taken = cond_model(flags_q, shadow[1], op.addr_b, op.addr_c[0]);
    @(negedge clk);
    check_equal("addr", addr, exp_addr);
    check_equal("we", 20'(we), 20'(op.mem_we));
    check_equal("m_io", 20'(m_io), 20'(op.m_io));
    check_equal("byteop", 20'(byteop), 20'(op.byte_op));
    check_equal("wr_data", 20'(wr_data), 20'(rc));
    check_equal("cs", 20'(cs), 20'(shadow[9]));
    check_equal("ip", 20'(ip), 20'(shadow[12]));
    check_equal("of", 20'(of), 20'(flags_q[flag_of]));
    check_equal("zf", 20'(zf), 20'(flags_q[flag_zf]));
    check_equal("ifl", 20'(ifl), 20'(flags_q[flag_if]));
    check_equal("cx_zero", 20'(cx_zero), 20'(shadow[1] == 16'h0000));
    if (!hold) begin
      if (op.wr || (op.wr_cnd && taken)) begin
        shadow = write_model(shadow, op.addr_d, op.byte_op,
                             op.mem_alu ? exp_addr[15:0] : mem_v);
      end
      if (op.wr_flags) begin
        flags_q = exp_flags;
      end
    end
  endtask

  function automatic micro_op_t make_op(input alu_type_e t, input alu_func_e f,
                                        input reg_sel_t src, input reg_sel_t dst);
    micro_op_t op;
    op = '0;
    op.op_type = t;
    op.func    = f;
    op.addr_a  = src;
    op.addr_d  = dst;
    op.mem_alu = 1'b1;
    return op;
  endfunction

  function automatic word_t rand_word();
    return word_t'($urandom());
  endfunction

  function automatic reg_sel_t rand_gp();
    return reg_sel_t'($urandom_range(7, 0));
  endfunction

  // odd values arrive over the memory read path, even ones through the ALU.
  task automatic load_reg(input reg_sel_t dst, input word_t value);
    micro_op_t op;
    op = make_op(alu_arith, func_pass_b, 4'd0, dst);
    op.b_imm = 1'b1;
    op.wr    = 1'b1;
    if (value[0]) begin
      op.mem_alu = 1'b0;
      step(op, 1'b0, ~value, 16'h0000, value);
    end else begin
      step(op, 1'b0, value, 16'h0000, ~value);
    end
  endtask

  task automatic read_back(input reg_sel_t sel);
    micro_op_t op;
    op = make_op(alu_arith, func_pass_b, 4'd0, 4'd0);
    op.addr_c = sel;
    step(op, 1'b0, 16'h0000, 16'h0000, 16'h0000);
  endtask

  // ##################################################
  // test sequences

  task automatic run_arith_writeback();
    reg_sel_t  src_a;
    reg_sel_t  src_b;
    reg_sel_t  dst;
    micro_op_t op;
    for (int i = 0; i < arith_runs; i++) begin
      src_a = rand_gp();
      src_b = reg_sel_t'((src_a + reg_sel_t'(1 + $urandom_range(6, 0))) & 4'd7);
      dst   = rand_gp();
      load_reg(src_a, rand_word());
      load_reg(src_b, rand_word());
      op = make_op(alu_arith, alu_func_e'(3'($urandom_range(7, 0))), src_a, dst);
      op.addr_b   = src_b;
      op.wr       = 1'b1;
      op.wr_flags = 1'b1;
      step(op, 1'b0, 16'h0000, 16'h0000, 16'h0000);
      read_back(dst);
    end
  endtask

  task automatic run_byte_lanes();
    micro_op_t op;
    for (int i = 0; i < byte_runs; i++) begin
      load_reg(4'd0, rand_word());
      // code 4 in byte mode is ah.
      op = make_op(alu_arith, func_pass_b, 4'd0, 4'd4);
      op.b_imm   = 1'b1;
      op.byte_op = 1'b1;
      op.wr      = 1'b1;
      step(op, 1'b0, rand_word(), 16'h0000, 16'h0000);
      read_back(4'd0);
    end
  endtask

  task automatic run_shifts();
    reg_sel_t  src;
    micro_op_t op;
    for (int i = 0; i < shift_runs; i++) begin
      src = rand_gp();
      load_reg(src, rand_word());
      op = make_op(alu_shift, shift_funcs[i % 5], src, src);
      op.wr       = 1'b1;
      op.wr_flags = 1'b1;
      step(op, 1'b0, 16'h0000, 16'h0000, 16'h0000);
      read_back(src);
    end
  endtask

  task automatic run_cond_writes();
    micro_op_t op;
    word_t     subtrahend;
    for (int code = 0; code < 16; code++) begin
      for (int inv = 0; inv < 2; inv++) begin
        load_reg(4'd0, rand_word());
        op = make_op(alu_arith, func_sub, 4'd0, 4'd1);
        op.b_imm    = 1'b1;
        op.wr       = 1'b1;
        op.wr_flags = 1'b1;
        // about a quarter of the runs leave cx at zero for the loop codes.
        subtrahend = ($urandom_range(3, 0) == 0) ? shadow[0] : rand_word();
        step(op, 1'b0, subtrahend, 16'h0000, 16'h0000);
        op = make_op(alu_arith, func_pass_b, 4'd0, 4'd2);
        op.b_imm  = 1'b1;
        op.wr_cnd = 1'b1;
        op.addr_b = reg_sel_t'(code);
        op.addr_c = reg_sel_t'(inv);
        step(op, 1'b0, ~shadow[2], 16'h0000, 16'h0000);
        read_back(4'd2);
      end
    end
  endtask

  task automatic run_block_hold();
    micro_op_t op;
    for (int i = 0; i < block_runs; i++) begin
      load_reg(4'd3, rand_word());
      // bx minus itself leaves zero and sets zf.
      op = make_op(alu_arith, func_sub, 4'd3, 4'd3);
      op.addr_b   = 4'd3;
      op.wr       = 1'b1;
      op.wr_flags = 1'b1;
      step(op, 1'b0, 16'h0000, 16'h0000, 16'h0000);
      op.b_imm  = 1'b1;
      op.mem_we = 1'b1;
      op.m_io   = 1'(i);
      step(op, 1'b1, rand_word() | 16'h0001, rand_word(), 16'h0000);
      read_back(4'd3);
    end
  endtask

  task automatic run_addr_gen();
    logic [1:0] seg_sel;
    reg_sel_t   base;
    micro_op_t  op;
    for (int i = 0; i < addr_runs; i++) begin
      seg_sel = 2'($urandom_range(3, 0));
      base    = rand_gp();
      load_reg(base, rand_word());
      load_reg({2'b10, seg_sel}, rand_word());
      op = make_op(alu_addr, func_add, base, 4'd0);
      op.addr_s   = seg_sel;
      op.wr_flags = 1'b1;
      op.mem_we   = 1'($urandom_range(1, 0));
      op.m_io     = 1'($urandom_range(1, 0));
      step(op, 1'b0, 16'h0000, rand_word(), 16'h0000);
    end
  endtask

  // ##################################################
  // run control

  initial begin
    clk     = 1'b0;
    rst     = 1'b1;
    block   = 1'b0;
    ir      = '0;
    off     = '0;
    imm     = '0;
    memout  = '0;
    errors  = 0;
    checks  = 0;
    shadow  = '0;
    shadow[9]  = cs_reset;
    shadow[12] = ip_reset;
    flags_q = flags_reset;
    shift_funcs[0] = func_shl;
    shift_funcs[1] = func_shr;
    shift_funcs[2] = func_sar;
    shift_funcs[3] = func_rol;
    shift_funcs[4] = func_ror;
    void'($urandom(32'hc80ef005));
    repeat (reset_cycles) @(posedge clk);
    rst <= 1'b0;
    read_back(4'd1);
    run_arith_writeback();
    run_byte_lanes();
    run_shifts();
    run_cond_writes();
    run_block_hold();
    run_addr_gen();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < max_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the test sequences did not finish within %0d cycles", max_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+testbench
source/exec_pkg.sv
source/exec_regfile.sv
source/exec_alu.sv
source/exec_jmp_cond.sv
source/exec_stage.sv
testbench/tb_exec_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
  --top-module tb_exec_stage \
  -f vlog.f

./obj_dir/Vtb_exec_stage | tee sim.log

if grep -q "Simulation failed" sim.log; then
  echo "run_sim: testbench reported errors"
  exit 1
fi

exit 0
